// File: Makefile
TOP = img_filter_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: rtl/apb_cmd_decode.sv
module apb_cmd_decode #(
  parameter int PIX_W      = 8,
  parameter int ROW_PIXELS = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [11:0]                   paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic                          busy,
  input  logic                          done,
  input  logic [31:0]                   res_lo,
  input  logic [31:0]                   res_hi,
  input  logic [31:0]                   sad,
  output img_pkg::img_cmd_e             cmd,
  output img_pkg::img_mode_e            mode,
  output logic [PIX_W*ROW_PIXELS-1:0]   row_data,
  output logic [PIX_W*ROW_PIXELS-1:0]   tpl_data
);

  localparam int ROW_W = PIX_W * ROW_PIXELS;

  logic [63:0]        pix_q;
  logic [63:0]        tpl_q;
  img_pkg::img_mode_e mode_q;
  logic               access;
  logic               mapped;
  logic               stall;
  logic               xfer;
  logic               wr_en;

  assign access = psel && penable;

  always_comb begin
    case (paddr)
      img_pkg::REG_CTRL,   img_pkg::REG_STATUS,
      img_pkg::REG_PIX_LO, img_pkg::REG_PIX_HI,
      img_pkg::REG_PUSH,
      img_pkg::REG_TPL_LO, img_pkg::REG_TPL_HI,
      img_pkg::REG_RES_LO, img_pkg::REG_RES_HI,
      img_pkg::REG_SAD:    mapped = 1'b1;
      default:             mapped = 1'b0;
    endcase
  end

  // hold off commands until the engine is free
  assign stall = access && pwrite && busy &&
                 (paddr == img_pkg::REG_CTRL || paddr == img_pkg::REG_PUSH);

  assign pready  = !stall;
  assign xfer    = access && pready;
  assign pslverr = xfer && !mapped;
  assign wr_en   = xfer && pwrite && mapped;

  always_comb begin
    cmd = img_pkg::CMD_NONE;
    if (wr_en && paddr == img_pkg::REG_PUSH) begin
      cmd = pwdata[0] ? img_pkg::CMD_ZERO : img_pkg::CMD_PUSH;
    end else if (wr_en && paddr == img_pkg::REG_CTRL) begin
      if (pwdata[8])
        cmd = img_pkg::CMD_START;
      else if (pwdata[1:0] == img_pkg::MODE_IDLE)
        cmd = img_pkg::CMD_CLEAR;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      mode_q <= img_pkg::MODE_IDLE;
    else if (wr_en && paddr == img_pkg::REG_CTRL)
      mode_q <= img_pkg::img_mode_e'(pwdata[1:0]);
  end

  // staged row and template halves
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (paddr)
        img_pkg::REG_PIX_LO: pix_q[31:0]  <= pwdata;
        img_pkg::REG_PIX_HI: pix_q[63:32] <= pwdata;
        img_pkg::REG_TPL_LO: tpl_q[31:0]  <= pwdata;
        img_pkg::REG_TPL_HI: tpl_q[63:32] <= pwdata;
        default: ;
      endcase
    end
  end

  assign mode     = mode_q;
  assign row_data = pix_q[ROW_W-1:0];
  assign tpl_data = tpl_q[ROW_W-1:0];

  always_comb begin
    case (paddr)
      img_pkg::REG_CTRL:   prdata = {30'd0, mode_q};
      img_pkg::REG_STATUS: prdata = {30'd0, done, busy};
      img_pkg::REG_PIX_LO: prdata = pix_q[31:0];
      img_pkg::REG_PIX_HI: prdata = pix_q[63:32];
      img_pkg::REG_TPL_LO: prdata = tpl_q[31:0];
      img_pkg::REG_TPL_HI: prdata = tpl_q[63:32];
      img_pkg::REG_RES_LO: prdata = res_lo;
      img_pkg::REG_RES_HI: prdata = res_hi;
      img_pkg::REG_SAD:    prdata = sad;
      default:             prdata = 32'd0;
    endcase
  end

endmodule

// File: rtl/filter_execute.sv
module filter_execute #(
  parameter int PIX_W      = 8,
  parameter int ROW_PIXELS = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  img_pkg::img_cmd_e           cmd,
  input  img_pkg::img_mode_e          mode,
  input  logic [PIX_W*ROW_PIXELS-1:0] row_0,
  input  logic [PIX_W*ROW_PIXELS-1:0] row_1,
  input  logic [PIX_W*ROW_PIXELS-1:0] row_2,
  input  logic [PIX_W*ROW_PIXELS-1:0] tpl_data,
  output logic                        busy,
  output logic                        res_valid,
  output logic [PIX_W*ROW_PIXELS-1:0] res_row,
  output logic [31:0]                 res_sad
);

  localparam int ROW_W = PIX_W * ROW_PIXELS;
  localparam int IDX_W = (ROW_PIXELS > 1) ? $clog2(ROW_PIXELS) : 1;
  // 16 * max pixel fits in PIX_W + 4 bits
  localparam int SUM_W = PIX_W + 4;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ROW_PIXELS - 1);

  img_pkg::exec_state_e state_q;
  logic [IDX_W-1:0]     idx_q;
  logic [ROW_W-1:0]     res_row_q;
  logic [31:0]          sad_q;
  logic [PIX_W-1:0]     gauss_pix;
  logic [PIX_W-1:0]     abs_diff;

  // zero outside the row
  function automatic logic [PIX_W-1:0] pix_at(input logic [ROW_W-1:0] row, input int c);
    if (c < 0 || c >= ROW_PIXELS)
      return '0;
    return row[c*PIX_W +: PIX_W];
  endfunction

  // vertical 1-2-1 over one column
  function automatic logic [SUM_W-1:0] col_sum(input logic [ROW_W-1:0] r0,
                                               input logic [ROW_W-1:0] r1,
                                               input logic [ROW_W-1:0] r2,
                                               input int c);
    logic [SUM_W-1:0] a;
    logic [SUM_W-1:0] b;
    logic [SUM_W-1:0] d;
    a = SUM_W'(pix_at(r2, c));
    b = SUM_W'(pix_at(r1, c));
    d = SUM_W'(pix_at(r0, c));
    return a + (b << 1) + d;
  endfunction

  always_comb begin
    int               c;
    logic [SUM_W-1:0] sum;
    logic [PIX_W-1:0] p;
    logic [PIX_W-1:0] t;
    c   = int'(idx_q);
    sum = col_sum(row_0, row_1, row_2, c - 1) +
          (col_sum(row_0, row_1, row_2, c) << 1) +
          col_sum(row_0, row_1, row_2, c + 1);
    // divide by 16, truncated
    gauss_pix = sum[SUM_W-1:4];
    p = pix_at(row_0, c);
    t = pix_at(tpl_data, c);
    abs_diff = (p >= t) ? p - t : t - p;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= img_pkg::ST_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        img_pkg::ST_IDLE: begin
          if (cmd == img_pkg::CMD_START) begin
            state_q <= img_pkg::ST_RUN;
            idx_q   <= '0;
          end
        end
        img_pkg::ST_RUN: begin
          if (idx_q == LAST_IDX)
            state_q <= img_pkg::ST_DONE;
          else
            idx_q <= idx_q + 1'b1;
        end
        img_pkg::ST_DONE: begin
          idx_q <= '0;
          if (cmd == img_pkg::CMD_START)
            state_q <= img_pkg::ST_RUN;
          else
            state_q <= img_pkg::ST_IDLE;
        end
        default: state_q <= img_pkg::ST_IDLE;
      endcase
    end
  end

  // one pixel per run cycle, idle mode leaves both results at zero
  always_ff @(posedge clk) begin
    if (cmd == img_pkg::CMD_START) begin
      res_row_q <= '0;
      sad_q     <= '0;
    end else if (state_q == img_pkg::ST_RUN) begin
      if (mode == img_pkg::MODE_GAUSSIAN)
        res_row_q[idx_q*PIX_W +: PIX_W] <= gauss_pix;
      if (mode == img_pkg::MODE_MATCH)
        sad_q <= sad_q + 32'(abs_diff);
    end
  end

  assign busy      = (state_q == img_pkg::ST_RUN);
  assign res_valid = (state_q == img_pkg::ST_DONE);
  assign res_row   = res_row_q;
  assign res_sad   = sad_q;

endmodule

// File: rtl/img_filter_top.sv
module img_filter_top #(
  parameter int PIX_W      = 8,
  parameter int ROW_PIXELS = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [11:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        busy
);

  localparam int ROW_W = PIX_W * ROW_PIXELS;

  img_pkg::img_cmd_e  cmd;
  img_pkg::img_mode_e mode;
  logic [ROW_W-1:0]   row_data;
  logic [ROW_W-1:0]   tpl_data;
  logic [ROW_W-1:0]   row_0;
  logic [ROW_W-1:0]   row_1;
  logic [ROW_W-1:0]   row_2;
  logic               res_valid;
  logic [ROW_W-1:0]   res_row;
  logic [31:0]        res_sad;
  logic [31:0]        res_lo;
  logic [31:0]        res_hi;
  logic [31:0]        sad;
  logic               done;

  apb_cmd_decode #(
    .PIX_W      (PIX_W),
    .ROW_PIXELS (ROW_PIXELS)
  ) u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .busy     (busy),
    .done     (done),
    .res_lo   (res_lo),
    .res_hi   (res_hi),
    .sad      (sad),
    .cmd      (cmd),
    .mode     (mode),
    .row_data (row_data),
    .tpl_data (tpl_data)
  );

  line_buffer #(
    .ROW_W (ROW_W)
  ) u_line_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .row_data (row_data),
    .row_0    (row_0),
    .row_1    (row_1),
    .row_2    (row_2)
  );

  filter_execute #(
    .PIX_W      (PIX_W),
    .ROW_PIXELS (ROW_PIXELS)
  ) u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .mode      (mode),
    .row_0     (row_0),
    .row_1     (row_1),
    .row_2     (row_2),
    .tpl_data  (tpl_data),
    .busy      (busy),
    .res_valid (res_valid),
    .res_row   (res_row),
    .res_sad   (res_sad)
  );

  result_regs #(
    .PIX_W      (PIX_W),
    .ROW_PIXELS (ROW_PIXELS)
  ) u_results (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .res_valid (res_valid),
    .res_row   (res_row),
    .res_sad   (res_sad),
    .res_lo    (res_lo),
    .res_hi    (res_hi),
    .sad       (sad),
    .done      (done)
  );

endmodule

// File: rtl/img_pkg.sv
package img_pkg;

  typedef enum logic [1:0] {
    MODE_IDLE     = 2'd0,
    MODE_GAUSSIAN = 2'd1,
    MODE_MATCH    = 2'd2
  } img_mode_e;

  typedef enum logic [2:0] {
    CMD_NONE  = 3'd0,
    CMD_PUSH  = 3'd1,
    CMD_ZERO  = 3'd2,
    CMD_CLEAR = 3'd3,
    CMD_START = 3'd4
  } img_cmd_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } exec_state_e;

  // apb register map
  localparam logic [11:0] REG_CTRL   = 12'h000;
  localparam logic [11:0] REG_STATUS = 12'h004;
  localparam logic [11:0] REG_PIX_LO = 12'h008;
  localparam logic [11:0] REG_PIX_HI = 12'h00C;
  localparam logic [11:0] REG_PUSH   = 12'h010;
  localparam logic [11:0] REG_TPL_LO = 12'h020;
  localparam logic [11:0] REG_TPL_HI = 12'h024;
  localparam logic [11:0] REG_RES_LO = 12'h040;
  localparam logic [11:0] REG_RES_HI = 12'h044;
  localparam logic [11:0] REG_SAD    = 12'h048;

endpackage

// File: rtl/line_buffer.sv
module line_buffer #(
  parameter int ROW_W = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  img_pkg::img_cmd_e cmd,
  input  logic [ROW_W-1:0]  row_data,
  output logic [ROW_W-1:0]  row_0,
  output logic [ROW_W-1:0]  row_1,
  output logic [ROW_W-1:0]  row_2
);

  logic [ROW_W-1:0] buf_0;
  logic [ROW_W-1:0] buf_1;
  logic [ROW_W-1:0] buf_2;

  // buf_0 is the newest row, buf_2 the oldest
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      buf_0 <= '0;
      buf_1 <= '0;
      buf_2 <= '0;
    end else begin
      case (cmd)
        img_pkg::CMD_PUSH: begin
          buf_0 <= row_data;
          buf_1 <= buf_0;
          buf_2 <= buf_1;
        end
        // edge padding row
        img_pkg::CMD_ZERO: begin
          buf_0 <= '0;
          buf_1 <= buf_0;
          buf_2 <= buf_1;
        end
        img_pkg::CMD_CLEAR: begin
          buf_0 <= '0;
          buf_1 <= '0;
          buf_2 <= '0;
        end
        default: ;
      endcase
    end
  end

  assign row_0 = buf_0;
  assign row_1 = buf_1;
  assign row_2 = buf_2;

endmodule

// File: rtl/result_regs.sv
module result_regs #(
  parameter int PIX_W      = 8,
  parameter int ROW_PIXELS = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  img_pkg::img_cmd_e           cmd,
  input  logic                        res_valid,
  input  logic [PIX_W*ROW_PIXELS-1:0] res_row,
  input  logic [31:0]                 res_sad,
  output logic [31:0]                 res_lo,
  output logic [31:0]                 res_hi,
  output logic [31:0]                 sad,
  output logic                        done
);

  logic [63:0] row_q;
  logic [31:0] sad_q;
  logic        done_q;

  // results survive later pushes, only a new run replaces them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_q <= '0;
      sad_q <= '0;
    end else if (res_valid) begin
      row_q <= 64'(res_row);
      sad_q <= res_sad;
    end
  end

  // sticky until the next start
  always_ff @(posedge clk) begin
    if (!rst_n)
      done_q <= 1'b0;
    else if (cmd == img_pkg::CMD_START)
      done_q <= 1'b0;
    else if (res_valid)
      done_q <= 1'b1;
  end

  assign res_lo = row_q[31:0];
  assign res_hi = row_q[63:32];
  assign sad    = sad_q;
  assign done   = done_q;

endmodule

// File: sources.f
rtl/img_pkg.sv
rtl/apb_cmd_decode.sv
rtl/line_buffer.sv
rtl/filter_execute.sv
rtl/result_regs.sv
rtl/img_filter_top.sv
tb/img_filter_props.sv
tb/img_filter_tb.sv

// File: tb/img_filter_props.sv
module img_filter_props (
  input logic              clk,
  input logic              rst_n,
  input logic              psel,
  input logic              penable,
  input logic              pready,
  input logic              pslverr,
  input logic              busy,
  input img_pkg::img_cmd_e cmd
);
  timeunit 1ns;
  timeprecision 1ps;

  // error response only on a completing beat
  a_slverr_ready: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> (psel && penable && pready))
    else $error("pslverr raised outside a completing transfer");

  a_cmd_on_xfer: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd != img_pkg::CMD_NONE) |-> (psel && penable && pready))
    else $error("command pulse without a completed transfer");

  a_no_push_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> (cmd != img_pkg::CMD_PUSH && cmd != img_pkg::CMD_ZERO))
    else $error("row push issued while the engine is busy");

  // engine picks up a start on the next edge
  a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd == img_pkg::CMD_START) |=> busy)
    else $error("busy did not rise after a start command");

endmodule

bind apb_cmd_decode img_filter_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .busy    (busy),
  .cmd     (cmd)
);

// File: tb/img_filter_tb.sv
module img_filter_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PIX_W      = 8;
  localparam int ROW_PIXELS = 8;
  localparam int NUM_OPS    = 10;
  localparam int WAIT_LIMIT = 50;
  localparam int POLL_LIMIT = 40;

  // zero[k] turns push k of an entry into a padding row
  typedef struct packed {
    img_pkg::img_mode_e mode;
    logic               clear;
    logic [1:0]         npush;
    logic [2:0]         zero;
    logic [2:0][63:0]   rows;
    logic [63:0]        tpl;
    logic [31:0]        exp_lo;
    logic [31:0]        exp_hi;
    logic [31:0]        exp_sad;
  } op_t;

  logic        clk;
  logic        rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        busy;

  logic [15:0] lfsr;
  logic [31:0] last_rdata;
  logic        last_err;
  int          last_waits;
  int          checks;
  int          mismatches;
  int          timeouts;
  op_t         ops [NUM_OPS];

  img_filter_top #(
    .PIX_W      (PIX_W),
    .ROW_PIXELS (ROW_PIXELS)
  ) uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .busy    (busy)
  );

  always #5 clk = ~clk;

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v[b] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // full 3x3 kernel with zero outside the row
  function automatic logic [63:0] gauss_model(input logic [63:0] newest,
                                              input logic [63:0] middle,
                                              input logic [63:0] oldest);
    int          w [3];
    logic [63:0] rows [3];
    logic [63:0] out;
    int          acc;
    int          col;
    w = '{1, 2, 1};
    rows[0] = oldest;
    rows[1] = middle;
    rows[2] = newest;
    out = '0;
    for (int c = 0; c < ROW_PIXELS; c++) begin
      acc = 0;
      for (int dr = 0; dr < 3; dr++) begin
        for (int dc = 0; dc < 3; dc++) begin
          col = c + dc - 1;
          if (col >= 0 && col < ROW_PIXELS)
            acc += w[dr] * w[dc] * int'(rows[dr][col*PIX_W +: PIX_W]);
        end
      end
      out[c*PIX_W +: PIX_W] = PIX_W'(acc / 16);
    end
    return out;
  endfunction

  function automatic logic [31:0] sad_model(input logic [63:0] row, input logic [63:0] tpl);
    int total;
    int a;
    int b;
    total = 0;
    for (int c = 0; c < ROW_PIXELS; c++) begin
      a = int'(row[c*PIX_W +: PIX_W]);
      b = int'(tpl[c*PIX_W +: PIX_W]);
      total += (a > b) ? a - b : b - a;
    end
    return 32'(total);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // setup and access phases driven on falling edges
  task automatic apb_access(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata);
    int waits;
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    waits = 0;
    @(posedge clk);
    while (pready !== 1'b1 && waits < WAIT_LIMIT) begin
      waits++;
      @(posedge clk);
    end
    if (pready !== 1'b1) begin
      $display("timeout: transfer to address %h never got pready", addr);
      timeouts++;
    end
    last_rdata = prdata;
    last_err   = pslverr;
    last_waits = waits;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_check(input logic [11:0] addr, input string name,
                            input logic [31:0] exp);
    apb_access(1'b0, addr, '0);
    check_value(name, last_rdata, exp);
  endtask

  task automatic wait_done();
    int polls;
    polls = 0;
    last_rdata = '0;
    while (last_rdata[1] !== 1'b1 && polls < POLL_LIMIT) begin
      apb_access(1'b0, img_pkg::REG_STATUS, '0);
      polls++;
    end
    if (last_rdata[1] !== 1'b1) begin
      $display("timeout: done flag never set after %0d status polls", polls);
      timeouts++;
    end
  endtask

  task automatic stage_row(input logic [63:0] row);
    apb_access(1'b1, img_pkg::REG_PIX_LO, row[31:0]);
    apb_access(1'b1, img_pkg::REG_PIX_HI, row[63:32]);
  endtask

  task automatic push_row(input logic zero, input logic [63:0] row);
    if (zero) begin
      apb_access(1'b1, img_pkg::REG_PUSH, 32'd1);
    end else begin
      stage_row(row);
      apb_access(1'b1, img_pkg::REG_PUSH, 32'd0);
    end
  endtask

  task automatic start_run(input img_pkg::img_mode_e mode);
    apb_access(1'b1, img_pkg::REG_CTRL, {23'd0, 1'b1, 6'd0, mode});
  endtask

  task automatic fill_table();
    logic [63:0] r;
    for (int i = 0; i < NUM_OPS; i++) begin
      ops[i] = '0;
      for (int k = 0; k < 3; k++) begin
        random_bits(64, r);
        ops[i].rows[k] = r;
      end
      random_bits(64, r);
      ops[i].tpl   = r;
      ops[i].npush = 2'd3;
    end
    ops[0].mode = img_pkg::MODE_GAUSSIAN;
    ops[1].mode = img_pkg::MODE_MATCH;
    // top and bottom image edges
    ops[2].mode = img_pkg::MODE_GAUSSIAN;
    ops[2].zero = 3'b001;
    ops[3].mode = img_pkg::MODE_GAUSSIAN;
    ops[3].zero = 3'b100;
    ops[4].mode = img_pkg::MODE_MATCH;
    ops[4].zero = 3'b100;
    ops[5].mode = img_pkg::MODE_GAUSSIAN;
    ops[5].rows = '1;
    ops[6].mode = img_pkg::MODE_MATCH;
    ops[6].tpl  = ops[6].rows[2];
    ops[7].mode  = img_pkg::MODE_GAUSSIAN;
    ops[7].clear = 1'b1;
    ops[7].npush = 2'd0;
    ops[8].mode  = img_pkg::MODE_MATCH;
    ops[8].clear = 1'b1;
    ops[8].npush = 2'd1;
    ops[9].mode  = img_pkg::MODE_IDLE;
  endtask

  // follows the buffer contents through the whole table
  task automatic predict_table();
    logic [63:0] b0;
    logic [63:0] b1;
    logic [63:0] b2;
    logic [63:0] g;
    b0 = '0;
    b1 = '0;
    b2 = '0;
    for (int i = 0; i < NUM_OPS; i++) begin
      if (ops[i].clear) begin
        b0 = '0;
        b1 = '0;
        b2 = '0;
      end
      for (int k = 0; k < int'(ops[i].npush); k++) begin
        b2 = b1;
        b1 = b0;
        b0 = ops[i].zero[k] ? 64'd0 : ops[i].rows[k];
      end
      g = '0;
      ops[i].exp_sad = '0;
      if (ops[i].mode == img_pkg::MODE_GAUSSIAN)
        g = gauss_model(b0, b1, b2);
      else if (ops[i].mode == img_pkg::MODE_MATCH)
        ops[i].exp_sad = sad_model(b0, ops[i].tpl);
      ops[i].exp_lo = g[31:0];
      ops[i].exp_hi = g[63:32];
    end
  endtask

  task automatic run_op(input int n);
    if (ops[n].clear)
      apb_access(1'b1, img_pkg::REG_CTRL, 32'd0);
    for (int k = 0; k < int'(ops[n].npush); k++)
      push_row(ops[n].zero[k], ops[n].rows[k]);
    apb_access(1'b1, img_pkg::REG_TPL_LO, ops[n].tpl[31:0]);
    apb_access(1'b1, img_pkg::REG_TPL_HI, ops[n].tpl[63:32]);
    start_run(ops[n].mode);
    check_value("busy", {31'd0, busy}, 32'd1);
    wait_done();
    check_value("busy", {31'd0, busy}, 32'd0);
    read_check(img_pkg::REG_RES_LO, "res_lo", ops[n].exp_lo);
    read_check(img_pkg::REG_RES_HI, "res_hi", ops[n].exp_hi);
    read_check(img_pkg::REG_SAD, "sad", ops[n].exp_sad);
    read_check(img_pkg::REG_STATUS, "status", 32'h2);
  endtask

  initial begin
    logic [63:0] ra;
    logic [63:0] rb;
    logic [63:0] rc;
    logic [63:0] rd;
    logic [63:0] g;
    clk        = 1'b0;
    rst_n      = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    lfsr       = 16'd19959;
    fill_table();
    predict_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_value("busy", {31'd0, busy}, 32'd0);
    read_check(img_pkg::REG_STATUS, "status", 32'h0);
    read_check(img_pkg::REG_RES_LO, "res_lo", 32'h0);
    read_check(img_pkg::REG_RES_HI, "res_hi", 32'h0);
    read_check(img_pkg::REG_SAD, "sad", 32'h0);

    for (int i = 0; i < NUM_OPS; i++)
      run_op(i);

    // push right behind a start waits until the run ends
    random_bits(64, ra);
    random_bits(64, rb);
    random_bits(64, rc);
    random_bits(64, rd);
    push_row(1'b0, ra);
    push_row(1'b0, rb);
    push_row(1'b0, rc);
    stage_row(rd);
    start_run(img_pkg::MODE_GAUSSIAN);
    apb_access(1'b1, img_pkg::REG_PUSH, 32'd0);
    check_value("push_stalled", {31'd0, last_waits > 0}, 32'd1);
    read_check(img_pkg::REG_STATUS, "status", 32'h2);
    g = gauss_model(rc, rb, ra);
    read_check(img_pkg::REG_RES_LO, "res_lo", g[31:0]);
    read_check(img_pkg::REG_RES_HI, "res_hi", g[63:32]);
    start_run(img_pkg::MODE_GAUSSIAN);
    read_check(img_pkg::REG_STATUS, "status", 32'h1);
    wait_done();
    g = gauss_model(rd, rc, rb);
    read_check(img_pkg::REG_RES_LO, "res_lo", g[31:0]);
    read_check(img_pkg::REG_RES_HI, "res_hi", g[63:32]);

    // unmapped addresses
    apb_access(1'b0, 12'h080, '0);
    check_value("pslverr", {31'd0, last_err}, 32'd1);
    apb_access(1'b1, 12'h0FC, 32'hFFFF_FFFF);
    check_value("pslverr", {31'd0, last_err}, 32'd1);
    read_check(img_pkg::REG_RES_LO, "res_lo", g[31:0]);
    read_check(img_pkg::REG_RES_HI, "res_hi", g[63:32]);
    read_check(img_pkg::REG_SAD, "sad", 32'h0);
    check_value("pslverr", {31'd0, last_err}, 32'd0);

    $display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
